/* source/arcade_input_pkg.sv */
//================================================
// Arcade input package
// Player, keyboard, analog, download and config
// types shared by the input front end
//================================================

package arcade_input_pkg;

    // Shared constants
    localparam logic [7:0] DIP_INDEX      = 8'd254;  // Download index of DIP switch bytes
    localparam int         ANALOG_PLAYERS = 2;
    localparam logic [7:0] PADDLE_CENTER  = 8'h7f;
    localparam logic [7:0] DPAD_RIGHT_VAL = 8'h40;
    localparam logic [7:0] DPAD_LEFT_VAL  = 8'hc0;

    // One player's control word
    typedef struct packed {
        logic       pause;
        logic       coin;
        logic       start;
        logic [5:0] buttons;
        logic [3:0] dir;       // 0 right, 1 left, 2 down, 3 up
    } player_t;

    // Keyboard state of one player
    typedef struct packed {
        logic       coin;
        logic       start;
        logic [7:0] keys;      // [3:0] dir, [7:4] low buttons
    } kb_player_t;

    typedef enum logic [1:0] {
        ANALOG_JOYSTICK = 2'd0,
        ANALOG_PADDLE   = 2'd1,
        ANALOG_SPINNER  = 2'd2,
        ANALOG_DPAD     = 2'd3
    } analog_mode_e;

    typedef struct packed {
        analog_mode_e mode;
        logic [2:0]   sens;    // Sensitivity step
        logic         invert;
    } analog_cfg_t;

    typedef struct packed {
        logic       abs_valid;
        logic       inc_valid;
        logic [7:0] p1;
        logic [7:0] p2;
    } analog_out_t;

    // Host download write, qualified by a separate strobe
    typedef struct packed {
        logic [7:0]  index;
        logic [24:0] addr;
        logic [7:0]  data;
    } dl_write_t;

endpackage

/* source/input_merger.sv */
//================================================
// Input merger
// ORs host joystick words with mapped keyboard
// keys per player and forms the combined pause
//================================================
`timescale 1ns/1ns

module input_merger #(
    parameter int NUM_PLAYERS = 4
) (
    input  logic                                          clk_sys,
    input  logic                                          rst_n,
    input  arcade_input_pkg::player_t    [NUM_PLAYERS-1:0] host_joy,
    input  arcade_input_pkg::kb_player_t [NUM_PLAYERS-1:0] kb,
    input  logic                                          kb_pause,
    output arcade_input_pkg::player_t    [NUM_PLAYERS-1:0] players,
    output logic                                          pause_any
);
    import arcade_input_pkg::*;

    player_t [NUM_PLAYERS-1:0] merged;
    logic                      merged_pause;

    // Keyboard record in control word layout
    function automatic player_t map_kb(input kb_player_t k, input logic p);
        player_t w;
        w         = '0;
        w.pause   = p;          // Pause key goes to every player
        w.coin    = k.coin;
        w.start   = k.start;
        w.buttons = {2'b00, k.keys[7:4]};
        w.dir     = k.keys[3:0];
        return w;
    endfunction

    always_comb begin
        merged_pause = 1'b0;
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            merged[i]    = player_t'(host_joy[i] | map_kb(kb[i], kb_pause));
            merged_pause = merged_pause | merged[i].pause;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            players   <= '0;
            pause_any <= 1'b0;
        end else begin
            players   <= merged;
            pause_any <= merged_pause;  // Same cycle as the merged words
        end
    end

endmodule

/* source/analog_conditioner.sv */
//================================================
// Analog conditioner
// Picks joystick, paddle, spinner or D-pad as the
// analog source of players 1 and 2, then scales
// and optionally inverts the value
//================================================
`timescale 1ns/1ns

module analog_conditioner (
    input  logic                                                        clk_sys,
    input  logic                                                        rst_n,
    input  arcade_input_pkg::analog_cfg_t                               cfg,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][7:0]            joy_x,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][7:0]            paddle,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][8:0]            spinner,
    input  arcade_input_pkg::player_t [arcade_input_pkg::ANALOG_PLAYERS-1:0] dpad_players,
    output arcade_input_pkg::analog_out_t                               analog
);
    import arcade_input_pkg::*;

    logic [ANALOG_PLAYERS-1:0]      prev_spin;  // Spinner bit 8 of the last cycle
    logic [ANALOG_PLAYERS-1:0][7:0] nxt_val;
    logic                           nxt_abs;
    logic                           nxt_inc;

    //================================================
    // Sensitivity and invert
    //================================================
    function automatic logic [7:0] scale(input logic [7:0] d, input logic [2:0] sens,
                                         input logic inv);
        logic [7:0] half;
        logic [7:0] quarter;
        logic [7:0] r;
        half    = $signed(d) >>> 1;
        quarter = $signed(d) >>> 2;
        case (sens)
            3'd0: r = d;
            3'd1: r = half;
            3'd2: r = quarter;
            3'd3: r = $signed(d) >>> 3;
            3'd4: r = $signed(d) >>> 4;
            3'd5: r = d + d;            // 200%
            3'd6: r = d + half;         // 150%
            default: r = d + quarter;   // 125%
        endcase
        if (inv && r != 8'h00) begin
            r = ~r;
        end
        return r;
    endfunction

    //================================================
    // Source select
    //================================================
    always_comb begin
        nxt_val = '0;
        nxt_abs = 1'b0;
        nxt_inc = 1'b0;
        for (int i = 0; i < ANALOG_PLAYERS; i++) begin
            case (cfg.mode)
                ANALOG_JOYSTICK: begin
                    nxt_val[i] = scale(joy_x[i], cfg.sens, cfg.invert);
                    nxt_abs    = 1'b1;
                end
                ANALOG_PADDLE: begin
                    nxt_val[i] = scale(paddle[i] - PADDLE_CENTER, cfg.sens, cfg.invert);
                    nxt_abs    = 1'b1;
                end
                ANALOG_SPINNER: begin
                    if (spinner[i][8] != prev_spin[i]) begin  // Bit 8 toggles per step
                        nxt_val[i] = scale(spinner[i][7:0], cfg.sens, cfg.invert);
                        nxt_inc    = 1'b1;
                    end
                end
                default: begin
                    if (dpad_players[i].dir[0]) begin
                        nxt_val[i] = scale(DPAD_RIGHT_VAL, cfg.sens, cfg.invert);
                    end else if (dpad_players[i].dir[1]) begin
                        nxt_val[i] = scale(DPAD_LEFT_VAL, cfg.sens, cfg.invert);
                    end else begin
                        nxt_val[i] = scale(8'h00, cfg.sens, cfg.invert);
                    end
                    nxt_abs = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            prev_spin <= '0;
            analog    <= '0;
        end else begin
            for (int i = 0; i < ANALOG_PLAYERS; i++) begin
                prev_spin[i] <= spinner[i][8];
            end
            analog.abs_valid <= nxt_abs;
            analog.inc_valid <= nxt_inc;
            analog.p1        <= nxt_val[0];
            analog.p2        <= nxt_val[1];
        end
    end

endmodule

/* source/dip_switch_bank.sv */
//================================================
// DIP switch bank
// Captures DIP bytes from the download stream,
// held active low, presented active high
//================================================
`timescale 1ns/1ns

module dip_switch_bank #(
    parameter int DIP_BANKS = 8
) (
    input  logic                            clk_sys,
    input  logic                            rst_n,
    input  logic                            dl_wr,
    input  arcade_input_pkg::dl_write_t     dl,
    output logic [DIP_BANKS-1:0][7:0]       dsw
);
    import arcade_input_pkg::*;

    localparam int SEL_W = $clog2(DIP_BANKS);

    logic [DIP_BANKS-1:0][7:0] dip_n;   // Bytes as downloaded, active low
    logic [SEL_W-1:0]          bank;
    logic                      hit;

    assign bank = dl.addr[SEL_W-1:0];

    // Only small addresses of the DIP index select a bank
    assign hit = dl_wr
              && dl.index == DIP_INDEX
              && (dl.addr >> SEL_W) == '0
              && int'(bank) < DIP_BANKS;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip_n <= '1;                 // All switches off
        end else if (hit) begin
            dip_n[bank] <= dl.data;
        end
    end

    assign dsw = ~dip_n;

endmodule

/* source/coin_pulser.sv */
//================================================
// Coin pulser
// Turns each coin press into a coin signal that
// lasts one frame between vblank rising edges
//================================================
`timescale 1ns/1ns

module coin_pulser #(
    parameter int NUM_PLAYERS = 4
) (
    input  logic                                       clk_sys,
    input  logic                                       rst_n,
    input  arcade_input_pkg::player_t [NUM_PLAYERS-1:0] players,
    input  logic                                       vblank,
    output logic [NUM_PLAYERS-1:0]                     coin
);
    import arcade_input_pkg::*;

    logic [NUM_PLAYERS-1:0] prev_btn;
    logic [NUM_PLAYERS-1:0] pending;
    logic [NUM_PLAYERS-1:0] btn_rise;
    logic                   vblank_q;
    logic                   vb_rise;

    assign vb_rise = vblank & ~vblank_q;

    always_comb begin
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            btn_rise[i] = players[i].coin & ~prev_btn[i];
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            prev_btn <= '0;
            pending  <= '0;
            coin     <= '0;
            vblank_q <= 1'b0;
        end else begin
            vblank_q <= vblank;
            for (int i = 0; i < NUM_PLAYERS; i++) begin
                prev_btn[i] <= players[i].coin;
            end
            if (vb_rise) begin
                coin    <= pending;   // Held for the whole frame
                pending <= btn_rise;  // A press on the edge waits a frame
            end else begin
                pending <= pending | btn_rise;
            end
        end
    end

endmodule

/* source/arcade_input_top.sv */
//================================================
// Arcade input top
// Player input front end: merger, analog
// conditioner, DIP bank and coin pulser
//================================================
`timescale 1ns/1ns

module arcade_input_top #(
    parameter int NUM_PLAYERS = 4,
    parameter int DIP_BANKS   = 8
) (
    input  logic                                                  clk_sys,
    input  logic                                                  rst_n,
    input  arcade_input_pkg::player_t    [NUM_PLAYERS-1:0]        host_joy,
    input  arcade_input_pkg::kb_player_t [NUM_PLAYERS-1:0]        kb,
    input  logic                                                  kb_pause,
    input  arcade_input_pkg::analog_cfg_t                         analog_cfg,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][7:0]      joy_x,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][7:0]      paddle,
    input  logic [arcade_input_pkg::ANALOG_PLAYERS-1:0][8:0]      spinner,
    input  logic                                                  dl_wr,
    input  arcade_input_pkg::dl_write_t                           dl,
    input  logic                                                  vblank,
    output arcade_input_pkg::player_t    [NUM_PLAYERS-1:0]        players,
    output logic                                                  pause_any,
    output arcade_input_pkg::analog_out_t                         analog,
    output logic [DIP_BANKS-1:0][7:0]                             dsw,
    output logic [NUM_PLAYERS-1:0]                                coin
);
    import arcade_input_pkg::*;

    input_merger #(.NUM_PLAYERS(NUM_PLAYERS)) u_merger (
        .clk_sys   (clk_sys),
        .rst_n     (rst_n),
        .host_joy  (host_joy),
        .kb        (kb),
        .kb_pause  (kb_pause),
        .players   (players),
        .pause_any (pause_any)
    );

    // D-pad mode reads the merged words of players 1 and 2
    analog_conditioner u_analog (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .cfg          (analog_cfg),
        .joy_x        (joy_x),
        .paddle       (paddle),
        .spinner      (spinner),
        .dpad_players (players[ANALOG_PLAYERS-1:0]),
        .analog       (analog)
    );

    dip_switch_bank #(.DIP_BANKS(DIP_BANKS)) u_dip (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .dl_wr   (dl_wr),
        .dl      (dl),
        .dsw     (dsw)
    );

    coin_pulser #(.NUM_PLAYERS(NUM_PLAYERS)) u_coin (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .players (players),
        .vblank  (vblank),
        .coin    (coin)
    );

endmodule

/* dv/arcade_input_asserts.sv */
//==================================================
// Arcade input assertions
// Analog valid flags and coin timing, bound into
// the input front end top level
//==================================================
`timescale 1ns/1ns

module arcade_input_asserts #(
    parameter int NUM_PLAYERS = 4
) (
    input logic                          clk_sys,
    input logic                          rst_n,
    input arcade_input_pkg::analog_cfg_t analog_cfg,
    input arcade_input_pkg::analog_out_t analog,
    input logic                          vblank,
    input logic [NUM_PLAYERS-1:0]        coin
);
    import arcade_input_pkg::*;

    // Absolute and incremental use exclude each other
    a_valid_excl: assert property (@(posedge clk_sys) disable iff (!rst_n)
        !(analog.abs_valid && analog.inc_valid))
        else $error("abs_valid and inc_valid high together");

    a_inc_spinner: assert property (@(posedge clk_sys) disable iff (!rst_n)
        analog.inc_valid |-> $past(analog_cfg.mode) == ANALOG_SPINNER)  // Flag lags mode by one
        else $error("inc_valid outside spinner mode");

    // Coin only moves right after a vblank rising edge
    a_coin_edge: assert property (@(posedge clk_sys) disable iff (!rst_n)
        coin != $past(coin) |-> $past(vblank) && !$past(vblank, 2))
        else $error("coin changed away from a vblank rising edge");

endmodule

bind arcade_input_top arcade_input_asserts #(.NUM_PLAYERS(NUM_PLAYERS)) u_asserts (.*);

/* dv/tb_arcade_input.sv */
//==================================================
// Arcade input testbench
// LFSR stimulus checked each cycle against a model
// of merger, analog, DIP bank and coin timing
//==================================================
`timescale 1ns/1ns

module tb_arcade_input;
    import arcade_input_pkg::*;

    localparam int NP         = 4;
    localparam int DB         = 8;
    localparam int RUN_CYCLES = 10 + 300 + 200 + 300 + 4;  // Reset, three phases, tail
    localparam int LIMIT      = RUN_CYCLES * 3 / 2;

    logic                           clk_sys = 1'b0;
    logic                           rst_n;
    player_t    [NP-1:0]            host_joy;
    kb_player_t [NP-1:0]            kb;
    logic                           kb_pause;
    analog_cfg_t                    analog_cfg;
    logic [ANALOG_PLAYERS-1:0][7:0] joy_x;
    logic [ANALOG_PLAYERS-1:0][7:0] paddle;
    logic [ANALOG_PLAYERS-1:0][8:0] spinner;
    logic                           dl_wr;
    dl_write_t                      dl;
    logic                           vblank;
    player_t    [NP-1:0]            players;
    logic                           pause_any;
    analog_out_t                    analog;
    logic [DB-1:0][7:0]             dsw;
    logic [NP-1:0]                  coin;

    // Reference model state
    player_t [NP-1:0]          m_players;
    logic                      m_pause_any;
    analog_out_t               m_analog;
    logic [ANALOG_PLAYERS-1:0] m_prev_spin;
    logic [DB-1:0][7:0]        m_dip_n;     // Active low, as downloaded
    logic [NP-1:0]             m_prev_btn;
    logic [NP-1:0]             m_pend;
    logic [NP-1:0]             m_coin;
    logic                      m_vb_q;

    logic [31:0] lfsr      = 32'h20e9;
    int          errors    = 0;
    int          checks    = 0;
    int          cycles    = 0;
    int          frame_pos = 0;

    arcade_input_top #(.NUM_PLAYERS(NP), .DIP_BANKS(DB)) UUT (.*);

    always #20 clk_sys = ~clk_sys;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = rand_bits(1);
        return r[0];
    endfunction

    function automatic logic [7:0] sens_scale(input logic [7:0] d, input analog_cfg_t cfg);
        int         v;
        int         r;
        logic [7:0] res;
        v = int'($signed(d));
        case (cfg.sens)
            3'd0:                   r = v;
            3'd1, 3'd2, 3'd3, 3'd4: r = v >>> cfg.sens;
            3'd5:                   r = 2 * v;
            3'd6:                   r = v + (v >>> 1);
            default:                r = v + (v >>> 2);
        endcase
        res = r[7:0];                        // Sums wrap mod 256
        if (cfg.invert && res != 8'h00) begin
            res = ~res;
        end
        return res;
    endfunction

    // Keys [3:0] land on dir, [7:4] on the low buttons
    function automatic player_t kb_word(input kb_player_t k, input logic p);
        return {p, k.coin, k.start, 2'b00, k.keys};
    endfunction

    function automatic logic [7:0] dpad_value(input player_t p);
        if (p.dir[0]) begin
            return DPAD_RIGHT_VAL;
        end
        return p.dir[1] ? DPAD_LEFT_VAL : 8'h00;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Phase 1 no spinner, phase 2 spinner only, phase 3 any mode
    task automatic drive_cycle(input int phase);
        logic [1:0] mode;
        @(posedge clk_sys);
        #2;
        for (int i = 0; i < NP; i++) begin
            host_joy[i]       = 13'(rand_bits(13));
            host_joy[i].pause = (rand_bits(3) == 32'd0);
            host_joy[i].coin  = (rand_bits(5) == 32'd0);   // Sparse coin presses
            kb[i]             = 10'(rand_bits(10));
            kb[i].coin        = (rand_bits(6) == 32'd0);
        end
        kb_pause   = (rand_bits(2) == 32'd0);
        analog_cfg = 6'(rand_bits(6));
        mode       = 2'(rand_bits(2));
        if (phase == 1 && mode == 2'd2) begin
            mode = 2'd3;
        end
        if (phase == 2) begin
            mode = 2'd2;
        end
        analog_cfg.mode = analog_mode_e'(mode);
        for (int i = 0; i < ANALOG_PLAYERS; i++) begin
            joy_x[i]   = 8'(rand_bits(8));
            paddle[i]  = 8'(rand_bits(8));
            spinner[i] = {spinner[i][8] ^ rand_bit(), 8'(rand_bits(8))};
        end
        dl_wr     = (rand_bits(2) == 32'd0);
        dl.index  = rand_bit() ? DIP_INDEX : 8'(rand_bits(8));
        dl.addr   = rand_bit() ? 25'(rand_bits(3)) : 25'(rand_bits(25));
        dl.data   = 8'(rand_bits(8));
        vblank    = (frame_pos < 2);                       // 12-cycle frames
        frame_pos = (frame_pos == 11) ? 0 : frame_pos + 1;
    endtask

    //==================================================
    // Reference model
    //==================================================
    always @(posedge clk_sys or negedge rst_n) begin
        logic [NP-1:0] rise;
        logic [7:0]    val [ANALOG_PLAYERS];
        logic          pause_acc;
        logic          inc;
        logic          vb_rise;
        if (!rst_n) begin
            m_players   <= '0;
            m_pause_any <= 1'b0;
            m_analog    <= '0;
            m_prev_spin <= '0;
            m_dip_n     <= '1;
            m_prev_btn  <= '0;
            m_pend      <= '0;
            m_coin      <= '0;
            m_vb_q      <= 1'b0;
        end else begin
            pause_acc = 1'b0;
            for (int i = 0; i < NP; i++) begin
                m_players[i] <= host_joy[i] | kb_word(kb[i], kb_pause);
                pause_acc     = pause_acc | host_joy[i].pause | kb_pause;
            end
            m_pause_any <= pause_acc;
            inc = 1'b0;
            for (int i = 0; i < ANALOG_PLAYERS; i++) begin
                val[i] = 8'h00;
                case (analog_cfg.mode)
                    ANALOG_JOYSTICK: val[i] = sens_scale(joy_x[i], analog_cfg);
                    ANALOG_PADDLE:   val[i] = sens_scale(paddle[i] - PADDLE_CENTER, analog_cfg);
                    ANALOG_SPINNER: begin
                        if (spinner[i][8] != m_prev_spin[i]) begin
                            val[i] = sens_scale(spinner[i][7:0], analog_cfg);
                            inc    = 1'b1;
                        end
                    end
                    default: val[i] = sens_scale(dpad_value(m_players[i]), analog_cfg);
                endcase
                m_prev_spin[i] <= spinner[i][8];
            end
            m_analog <= {analog_cfg.mode != ANALOG_SPINNER, inc, val[0], val[1]};
            if (dl_wr && dl.index == DIP_INDEX && dl.addr < 25'(DB)) begin
                m_dip_n[dl.addr[2:0]] <= dl.data;
            end
            // Coin button is the registered merged word
            vb_rise = vblank && !m_vb_q;
            m_vb_q <= vblank;
            for (int i = 0; i < NP; i++) begin
                rise[i]       = m_players[i].coin && !m_prev_btn[i];
                m_prev_btn[i] <= m_players[i].coin;
            end
            if (vb_rise) begin
                m_coin <= m_pend;
                m_pend <= rise;
            end else begin
                m_pend <= m_pend | rise;
            end
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk_sys) begin
        for (int i = 0; i < NP; i++) begin
            check_value($sformatf("players[%0d]", i), 64'(players[i]), 64'(m_players[i]));
        end
        check_value("pause_any", 64'(pause_any), 64'(m_pause_any));
        check_value("analog.p1", 64'(analog.p1), 64'(m_analog.p1));
        check_value("analog.p2", 64'(analog.p2), 64'(m_analog.p2));
        check_value("analog.abs_valid", 64'(analog.abs_valid), 64'(m_analog.abs_valid));
        check_value("analog.inc_valid", 64'(analog.inc_valid), 64'(m_analog.inc_valid));
        check_value("dsw", 64'(dsw), 64'(~m_dip_n));
        check_value("coin", 64'(coin), 64'(m_coin));
    end

    always @(posedge clk_sys) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        host_joy   = '0;
        kb         = '0;
        kb_pause   = 1'b0;
        analog_cfg = '0;
        joy_x      = '0;
        paddle     = '0;
        spinner    = '0;
        dl_wr      = 1'b0;
        dl         = '0;
        vblank     = 1'b0;
        repeat (10) @(posedge clk_sys);
        #2;
        rst_n = 1'b1;
        repeat (300) drive_cycle(1);
        repeat (200) drive_cycle(2);
        repeat (300) drive_cycle(3);
        repeat (3) @(posedge clk_sys);
        #5;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* build.f */
source/arcade_input_pkg.sv
source/input_merger.sv
source/analog_conditioner.sv
source/dip_switch_bank.sv
source/coin_pulser.sv
source/arcade_input_top.sv
dv/arcade_input_asserts.sv
dv/tb_arcade_input.sv

/* Makefile */
# Verilator build and run of the arcade input testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module tb_arcade_input \
		-f build.f -Mdir obj_dir

# The run passes only if the log holds the pass line
run: compile
	./obj_dir/Vtb_arcade_input | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log
